// ==== crypto_pkg.sv ====
`default_nettype none

package crypto_pkg;

    // ============================================================
    // data path
    // ============================================================

    localparam int XLEN = 32;

    // number of implemented operations, funct3 codes 0..NUM_OPS-1
    localparam int NUM_OPS = 6;

    // ============================================================
    // instruction encoding
    // ============================================================

    // custom-0 major opcode
    localparam logic [6:0] CRYPTO_OPCODE = 7'b000_1011;

    // funct7 value reserved for this extension
    localparam logic [6:0] CRYPTO_FUNCT7 = 7'b000_0100;

    // funct3 values, 6 and 7 are unused
    typedef enum logic [2:0] {
        OP_HMDST = 3'd0,
        OP_PKG   = 3'd1,
        OP_RVRS  = 3'd2,
        OP_SLADD = 3'd3,
        OP_CNTZ  = 3'd4,
        OP_CNTP  = 3'd5
    } crypto_op_e;

    // ============================================================
    // issue control
    // ============================================================

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        DONE = 2'd1,
        HOLD = 2'd2
    } issue_state_e;

endpackage

`default_nettype wire

// ==== crypto_insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_insn_decoder (
    input  logic [crypto_pkg::XLEN-1:0] instr_i,
    output crypto_pkg::crypto_op_e      op_o,
    output logic                        legal_o
);

    import crypto_pkg::*;

    // R-type fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to operation
    always_comb begin
        case (funct3)
            3'd0: op_o = OP_HMDST;
            3'd1: op_o = OP_PKG;
            3'd2: op_o = OP_RVRS;
            3'd3: op_o = OP_SLADD;
            3'd4: op_o = OP_CNTZ;
            3'd5: op_o = OP_CNTP;
            default: begin
                // op is a don't care here, legal_o masks it
                op_o = OP_HMDST;
            end
        endcase
    end

    // foreign opcode or funct7 belongs to another extension
    assign legal_o = (opcode == CRYPTO_OPCODE) &&
                     (funct7 == CRYPTO_FUNCT7) &&
                     (int'(funct3) < NUM_OPS);

endmodule

`default_nettype wire

// ==== crypto_issue_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_issue_fsm (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic active_i,
    input  logic stall_i,
    input  logic legal_i,
    output logic accept_o,
    output logic clear_o,
    output logic ready_o,
    output logic illegal_o
);

    import crypto_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;
    logic         ready_q;

    // ============================================================
    // acceptance and next state
    // ============================================================

    assign accept_o = (state_q == IDLE) && active_i && !stall_i && legal_i;

    always_comb begin
        state_d = state_q;
        if (!active_i) begin
            // stage emptied, drop whatever was in flight
            state_d = IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept_o) begin
                        state_d = DONE;
                    end
                end
                DONE: begin
                    state_d = stall_i ? HOLD : IDLE;
                end
                HOLD: begin
                    if (!stall_i) begin
                        state_d = IDLE;
                    end
                end
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // high exactly in DONE
            ready_q <= accept_o;
        end
    end

    assign ready_o   = ready_q;
    assign clear_o   = !active_i;
    assign illegal_o = active_i && !legal_i;

    // ============================================================
    // checks
    // ============================================================

    // one pulse per accepted instruction
    a_ready_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_o |=> !ready_o);

    // no second issue while the previous result is still pending
    a_accept_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept_o |-> !ready_o);

endmodule

`default_nettype wire

// ==== crypto_bitmanip_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_bitmanip_unit (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        accept_i,
    input  logic                        clear_i,
    input  crypto_pkg::crypto_op_e      op_i,
    input  logic [crypto_pkg::XLEN-1:0] rs1_i,
    input  logic [crypto_pkg::XLEN-1:0] rs2_i,
    output logic [crypto_pkg::XLEN-1:0] result_o
);

    import crypto_pkg::*;

    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] rev;
    logic [XLEN-1:0] result_d;
    logic [XLEN-1:0] result_q;

    // ============================================================
    // helpers
    // ============================================================

    // octal digit sums, then sum of digits via modulo 63
    function automatic logic [XLEN-1:0] popcount(input logic [XLEN-1:0] x);
        logic [XLEN-1:0] v;
        v = x - ((x >> 1) & 32'hdb6d_b6db) - ((x >> 2) & 32'h4924_9249);
        return ((v + (v >> 3)) & 32'hc71c_71c7) % 63;
    endfunction

    // binary search for the lowest set bit
    function automatic logic [XLEN-1:0] ctz(input logic [XLEN-1:0] x);
        logic [XLEN-1:0] v;
        logic [5:0]      n;
        v = x;
        n = '0;
        if (x == '0) begin
            return XLEN;
        end
        if (v[15:0] == '0) begin
            n = n + 6'd16;
            v = v >> 16;
        end
        if (v[7:0] == '0) begin
            n = n + 6'd8;
            v = v >> 8;
        end
        if (v[3:0] == '0) begin
            n = n + 6'd4;
            v = v >> 4;
        end
        if (v[1:0] == '0) begin
            n = n + 6'd2;
            v = v >> 2;
        end
        if (!v[0]) begin
            n = n + 6'd1;
        end
        return {{(XLEN-6){1'b0}}, n};
    endfunction

    // ============================================================
    // operation select
    // ============================================================

    assign diff = rs1_i ^ rs2_i;

    always_comb begin
        for (int k = 0; k < XLEN; k++) begin
            rev[XLEN-1-k] = rs1_i[k];
        end
    end

    always_comb begin
        case (op_i)
            OP_HMDST: result_d = popcount(diff);
            OP_PKG:   result_d = {rs2_i[XLEN/2-1:0], rs1_i[XLEN/2-1:0]};
            OP_RVRS:  result_d = rev;
            OP_SLADD: result_d = (rs1_i << 1) + rs2_i;
            OP_CNTZ:  result_d = ctz(rs1_i);
            OP_CNTP:  result_d = popcount(rs1_i);
            default:  result_d = '0;
        endcase
    end

    // ============================================================
    // result register
    // ============================================================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
        end else if (clear_i) begin
            result_q <= '0;
        end else if (accept_i) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

    // counting ops land in 0..32 one cycle after issue
    a_count_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept_i && !clear_i && (op_i inside {OP_HMDST, OP_CNTZ, OP_CNTP})
        |=> (result_o <= XLEN));

endmodule

`default_nettype wire

// ==== crypto_op_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_op_counter #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   inc_i,
    input  crypto_pkg::crypto_op_e op_i,
    input  logic [2:0]             sel_i,
    output logic [CNT_WIDTH-1:0]   cnt_o
);

    import crypto_pkg::*;

    logic [CNT_WIDTH-1:0] cnt_q [NUM_OPS];

    // one retired counter per opcode, wraps at full scale
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (inc_i) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                if (int'(op_i) == i) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // read port, unused codes read as zero
    always_comb begin
        cnt_o = '0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (int'(sel_i) == i) begin
                cnt_o = cnt_q[i];
            end
        end
    end

    // every increment hits an implemented opcode
    a_inc_valid_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inc_i |-> (int'(op_i) < NUM_OPS));

endmodule

`default_nettype wire

// ==== crypto_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_exec_top #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        active_i,
    input  logic                        stall_i,
    input  logic [crypto_pkg::XLEN-1:0] instr_i,
    input  logic [crypto_pkg::XLEN-1:0] rs1_i,
    input  logic [crypto_pkg::XLEN-1:0] rs2_i,
    input  logic [2:0]                  cnt_sel_i,
    output logic [crypto_pkg::XLEN-1:0] result_o,
    output logic                        ready_o,
    output logic                        illegal_o,
    output logic [CNT_WIDTH-1:0]        cnt_o
);

    import crypto_pkg::*;

    crypto_op_e op;
    logic       legal;
    logic       accept;
    logic       clear;

    // ============================================================
    // decode and issue control
    // ============================================================

    crypto_insn_decoder u_decoder (
        .instr_i (instr_i),
        .op_o    (op),
        .legal_o (legal)
    );

    crypto_issue_fsm u_issue_fsm (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .active_i  (active_i),
        .stall_i   (stall_i),
        .legal_i   (legal),
        .accept_o  (accept),
        .clear_o   (clear),
        .ready_o   (ready_o),
        .illegal_o (illegal_o)
    );

    // ============================================================
    // data path and statistics
    // ============================================================

    crypto_bitmanip_unit u_bitmanip (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .accept_i (accept),
        .clear_i  (clear),
        .op_i     (op),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .result_o (result_o)
    );

    crypto_op_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_op_counter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .inc_i    (accept),
        .op_i     (op),
        .sel_i    (cnt_sel_i),
        .cnt_o    (cnt_o)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

    // release just after an edge, away from the sampling point
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #5;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== crypto_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_exec_tb;

    localparam int NUM_RANDOM = 24;
    localparam int MAX_WAIT   = 4;

    logic        clk;
    logic        arst_n;
    logic        active;
    logic        stall;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [2:0]  cnt_sel;
    logic [31:0] result;
    logic        ready;
    logic        illegal;
    logic [15:0] cnt;

    logic [31:0] vec_instr[$];
    logic [31:0] vec_rs1[$];
    logic [31:0] vec_rs2[$];
    logic [31:0] vec_exp[$];
    int          vec_stall[$];
    int          tally[6];
    int          errors;
    int          checks;
    int          timeout_cycles;
    integer      seed;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    crypto_exec_top #(.CNT_WIDTH(16)) uut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .active_i  (active),
        .stall_i   (stall),
        .instr_i   (instr),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .cnt_sel_i (cnt_sel),
        .result_o  (result),
        .ready_o   (ready),
        .illegal_o (illegal),
        .cnt_o     (cnt)
    );

    // ============================================================
    // helpers
    // ============================================================

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // bit by bit model of the six operations
    function automatic logic [31:0] expected_result(input logic [2:0] op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [31:0] r;
        logic        seen;
        r    = '0;
        seen = 1'b0;
        for (int i = 0; i < 32; i++) begin
            case (op)
                3'd0: r = (a[i] != b[i]) ? r + 1 : r;
                3'd2: r[31-i] = a[i];
                3'd4: begin
                    if (a[i]) seen = 1'b1;
                    else if (!seen) r = r + 1;
                end
                3'd5: r = a[i] ? r + 1 : r;
                default: ;
            endcase
        end
        if (op == 3'd1) r = {b[15:0], a[15:0]};
        if (op == 3'd3) r = a + a + b;
        return r;
    endfunction

    task automatic load_stimulus();
        int          fd;
        string       line;
        logic [31:0] f_instr, f_rs1, f_rs2, f_exp;
        int          f_stall;
        fd = $fopen("crypto_exec_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open crypto_exec_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%h %h %h %d %h", f_instr, f_rs1, f_rs2, f_stall,
                            f_exp) == 5) begin
                    vec_instr.push_back(f_instr);
                    vec_rs1.push_back(f_rs1);
                    vec_rs2.push_back(f_rs2);
                    vec_stall.push_back(f_stall);
                    vec_exp.push_back(f_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_counters();
        for (int s = 0; s < 8; s++) begin
            cnt_sel = 3'(s);
            #1;
            check_value(32'(cnt), (s < 6) ? 32'(tally[s]) : 32'd0,
                        $sformatf("counter %0d", s));
        end
        cnt_sel = 3'd0;
    endtask

    // ============================================================
    // one instruction through the execute stage
    // ============================================================

    task automatic run_vector(input logic [31:0] insn, input logic [31:0] a,
                              input logic [31:0] b, input int stall_cycles,
                              input logic [31:0] want);
        logic legal;
        int   waited;
        legal = (insn[6:0] == 7'b000_1011) && (insn[31:25] == 7'b000_0100) &&
                (insn[14:12] < 3'd6);
        @(posedge clk);
        #5;
        active = 1'b1;
        instr  = insn;
        rs1    = a;
        rs2    = b;
        stall  = 1'b0;
        #1;
        check_value(32'(illegal), 32'(!legal), "illegal_o");
        if (legal) begin
            waited = 0;
            do begin
                @(posedge clk);
                #1;
                waited++;
            end while (!ready && waited < MAX_WAIT);
            if (!ready) begin
                errors++;
                $display("ready_o never rose for instruction %h at %0t", insn, $time);
            end else begin
                check_value(32'(waited), 32'd1, "ready_o latency");
                check_value(result, want, "result_o");
                tally[insn[14:12]]++;
            end
            #4;
            if (stall_cycles > 0) begin
                stall = 1'b1;
                repeat (stall_cycles) begin
                    @(posedge clk);
                    #1;
                    check_value(32'(ready), 32'd0, "ready_o under stall");
                    check_value(result, want, "result_o under stall");
                    #4;
                end
                stall = 1'b0;
                @(posedge clk);
                #1;
                check_value(result, want, "result_o after stall");
                #4;
            end
            active = 1'b0;
            @(posedge clk);
            #1;
            check_value(result, 32'd0, "result_o after deactivation");
        end else begin
            repeat (3) begin
                @(posedge clk);
                #1;
                check_value(32'(ready), 32'd0, "ready_o on illegal");
                check_value(result, 32'd0, "result_o on illegal");
            end
            #4;
            active = 1'b0;
        end
    endtask

    initial begin : watchdog
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", timeout_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [2:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        active  = 1'b0;
        stall   = 1'b0;
        instr   = '0;
        rs1     = '0;
        rs2     = '0;
        cnt_sel = '0;
        errors  = 0;
        checks  = 0;
        seed    = 32'h84c7_ef8a;
        foreach (tally[i]) tally[i] = 0;
        load_stimulus();
        timeout_cycles = (vec_instr.size() + NUM_RANDOM) * 10 + 100;

        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        check_value(result, 32'd0, "result_o after reset");
        check_value(32'(ready), 32'd0, "ready_o after reset");
        #4;
        check_counters();

        foreach (vec_instr[i]) begin
            run_vector(vec_instr[i], vec_rs1[i], vec_rs2[i], vec_stall[i], vec_exp[i]);
        end

        for (int k = 0; k < NUM_RANDOM; k++) begin
            op = 3'({$random(seed)} % 6);
            a  = $random(seed);
            b  = $random(seed);
            // give count trailing zeros some real runs, including all zero
            if (op == 3'd4) a = a << ({$random(seed)} % 33);
            run_vector({7'b000_0100, 5'd12, 5'd11, op, 5'd10, 7'b000_1011}, a, b,
                       int'({$random(seed)} % 3), expected_result(op, a, b));
        end

        @(posedge clk);
        #5;
        check_counters();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== crypto_exec_stim.txt ====
# instr    rs1      rs2      stall  expected   (all hex except stall)
# stall = cycles stall_i stays high after acceptance, decimal
08C5850B FFFF0000 0000FFFF 0 00000020
08C5950B AAAA1234 BBBB5678 0 56781234
08C5A50B 00000001 00000000 0 80000000
08C5A50B 12345678 00000000 0 1E6A2C48
08C5B50B 00000010 00000003 0 00000023
08C5B50B 80000001 FFFFFFFF 0 00000001
08C5C50B 00000000 00000000 0 00000020
08C5C50B 00010000 00000000 0 00000010
08C5D50B FFFFFFFF 00000000 0 00000020
08C5D50B 0F0F00F1 00000000 0 0000000D
08C5950B 0000BEEF 0000CAFE 3 CAFEBEEF
08C5C50B 80000000 00000000 2 0000001F
08C5E50B 12345678 9ABCDEF0 0 00000000
08C5F50B 12345678 9ABCDEF0 0 00000000
08C5852B 12345678 9ABCDEF0 0 00000000
00C5850B 12345678 9ABCDEF0 0 00000000

// ==== crypto_exec_top.f ====
crypto_pkg.sv
crypto_insn_decoder.sv
crypto_issue_fsm.sv
crypto_bitmanip_unit.sv
crypto_op_counter.sv
crypto_exec_top.sv
tb_clock_gen.sv
crypto_exec_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := crypto_exec_tb
RTL_TOP    := crypto_exec_top
FILELIST   := crypto_exec_top.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall
RTL_SRCS   := crypto_pkg.sv crypto_insn_decoder.sv crypto_issue_fsm.sv \
              crypto_bitmanip_unit.sv crypto_op_counter.sv crypto_exec_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
